// ==== sources.f ====
logic/trs_dbg_pkg.sv
logic/spi_target.sv
logic/cmd_decoder.sv
logic/bp_slot.sv
logic/bp_halt_ctrl.sv
logic/bus_ram.sv
logic/trs_dbg_top.sv
bench/spi_host.sv
bench/tb_trs_dbg_top.sv

// ==== Bender.yml ====
package:
  name: trs_dbg

sources:
  - logic/trs_dbg_pkg.sv
  - logic/spi_target.sv
  - logic/cmd_decoder.sv
  - logic/bp_slot.sv
  - logic/bp_halt_ctrl.sv
  - logic/bus_ram.sv
  - logic/trs_dbg_top.sv
  - target: test
    files:
      - bench/spi_host.sv
      - bench/tb_trs_dbg_top.sv

// ==== bench/tb_trs_dbg_top.sv ====
module tb_trs_dbg_top;
  import trs_dbg_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int SPI_HALF      = 8;
  localparam int N_RAND        = 8;
  localparam int N_LOW         = 4;
  localparam int N_FRAMES      = 2 + 2 * N_RAND + 10;
  localparam int N_ACCESS      = 2 * N_RAND + N_LOW + 3;
  localparam int N_HALTS       = 3;
  localparam int FRAME_CYCLES  = (4 * 8 * 2 + 6) * SPI_HALF;  // longest frame is 4 bytes
  localparam int ACCESS_CYCLES = 16;
  localparam int HALT_CYCLES   = 40;
  localparam int RUN_CYCLES    = 16 + N_FRAMES * FRAME_CYCLES + N_ACCESS * ACCESS_CYCLES +
                                 N_HALTS * HALT_CYCLES;

  // host command codes
  localparam byte_t OP_COOKIE  = 8'h00;
  localparam byte_t OP_POKE    = 8'h01;
  localparam byte_t OP_PEEK    = 8'h02;
  localparam byte_t OP_SET_BP  = 8'h06;
  localparam byte_t OP_CLR_BP  = 8'h07;
  localparam byte_t OP_ENABLE  = 8'h0b;
  localparam byte_t OP_DISABLE = 8'h0c;
  localparam byte_t OP_VERSION = 8'h0f;

  localparam byte_t EXP_COOKIE  = 8'haf;
  localparam byte_t EXP_VERSION = 8'h03; // major 0 in [7:5], minor 3 in [4:0]

  logic    clk;
  logic    rst;
  logic    sck;
  logic    mosi;
  logic    cs_n;
  logic    miso;
  addr_t   mem_addr;
  logic    mem_rd;
  logic    mem_wr;
  byte_t   mem_wdata;
  byte_t   mem_rdata;
  logic    mem_rvalid;
  logic    mem_wait;
  logic    brk_req;
  bp_idx_t brk_idx;
  logic    brk_ack;
  int      seed   = 32'hb29b9b5f;

  trs_dbg_top #(
    .RAM_ADDR_W(15),
    .NUM_BP    (8)
  ) i_trs_dbg_top (
    .clk       (clk),
    .rst       (rst),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .miso      (miso),
    .mem_addr  (mem_addr),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_rvalid(mem_rvalid),
    .mem_wait  (mem_wait),
    .brk_req   (brk_req),
    .brk_idx   (brk_idx),
    .brk_ack   (brk_ack)
  );

  spi_host #(
    .HALF(SPI_HALF)
  ) i_spi_host (
    .clk (clk),
    .sck (sck),
    .mosi(mosi),
    .cs_n(cs_n),
    .miso(miso)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(RUN_CYCLES * 2 * CLK_PERIOD);
    stop_with_error("timeout, the run did not finish in the expected time");
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    assert (act === exp) else
      stop_with_error($sformatf("Mismatch in %s: expected %0h, actual %0h", name, exp, act));
  endtask

  assert property (@(posedge clk) disable iff (rst) mem_rvalid |=> !mem_rvalid)
    else stop_with_error("mem_rvalid stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (rst) $fell(brk_req) |-> brk_ack)
    else stop_with_error("brk_req fell while brk_ack was low");
  assert property (@(posedge clk) disable iff (rst) $fell(mem_wait) |-> !brk_ack)
    else stop_with_error("mem_wait fell while brk_ack was still high");

  task automatic check_idle(input string name);
    check_value({name, " brk_req"}, 0, brk_req);
    check_value({name, " mem_wait"}, 0, mem_wait);
    check_value({name, " mem_rvalid"}, 0, mem_rvalid);
    check_value({name, " miso"}, 0, miso);
  endtask

  // host side commands
  task automatic query(input byte_t op, output byte_t reply);
    i_spi_host.send_frame(2, op, 8'h00, 8'h00, 8'h00, reply);
  endtask

  task automatic one_byte_cmd(input byte_t op);
    byte_t dummy;
    i_spi_host.send_frame(1, op, 8'h00, 8'h00, 8'h00, dummy);
  endtask

  task automatic poke(input addr_t a, input byte_t d);
    byte_t dummy;
    i_spi_host.send_frame(4, OP_POKE, a[7:0], a[15:8], d, dummy);
  endtask

  task automatic peek(input addr_t a, output byte_t d);
    i_spi_host.send_frame(4, OP_PEEK, a[7:0], a[15:8], 8'h00, d);
  endtask

  task automatic set_breakpoint(input bp_idx_t slot, input addr_t a);
    byte_t dummy;
    i_spi_host.send_frame(4, OP_SET_BP, {5'd0, slot}, a[7:0], a[15:8], dummy);
  endtask

  task automatic clear_breakpoint(input bp_idx_t slot);
    byte_t dummy;
    i_spi_host.send_frame(2, OP_CLR_BP, {5'd0, slot}, 8'h00, 8'h00, dummy);
  endtask

  // counts cycles from the first edge that samples the strobe until mem_rvalid
  task automatic wait_rvalid(input string name, input byte_t exp, output int lat);
    lat = 0;
    @(negedge clk);
    while (!mem_rvalid && lat < 12) begin
      @(negedge clk);
      lat++;
    end
    assert (mem_rvalid) else stop_with_error({"no mem_rvalid for read ", name});
    check_value({name, " latency"}, 4, lat);
    check_value({name, " data"}, exp, mem_rdata);
  endtask

  // bus side accesses
  task automatic read_bus(input addr_t a, input byte_t exp, input string name);
    int lat;
    @(posedge clk);
    mem_addr <= a;
    mem_rd   <= 1'b1;
    @(posedge clk);
    wait_rvalid(name, exp, lat);
    check_value({name, " mem_wait"}, 0, mem_wait);
    @(posedge clk);
    mem_rd <= 1'b0;
    @(posedge clk);
  endtask

  task automatic read_outside(input addr_t a, input string name);
    @(posedge clk);
    mem_addr <= a;
    mem_rd   <= 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_value({name, " mem_rvalid"}, 0, mem_rvalid);
    end
    @(posedge clk);
    mem_rd <= 1'b0;
    @(posedge clk);
  endtask

  task automatic write_bus(input addr_t a, input byte_t d, input string name);
    @(posedge clk);
    mem_addr  <= a;
    mem_wdata <= d;
    mem_wr    <= 1'b1;
    repeat (8) begin
      @(negedge clk);
      check_value({name, " mem_wait"}, 0, mem_wait);
      check_value({name, " mem_rvalid"}, 0, mem_rvalid);
    end
    @(posedge clk);
    mem_wr <= 1'b0;
    @(posedge clk);
  endtask

  task automatic read_halted(input addr_t a, input bp_idx_t idx, input byte_t exp,
                             input string name);
    int cnt;
    int lat;
    cnt = 0;
    @(posedge clk);
    mem_addr <= a;
    mem_rd   <= 1'b1;
    @(negedge clk);
    while (!brk_req && cnt < 10) begin
      @(negedge clk);
      cnt++;
    end
    assert (brk_req) else stop_with_error({"no brk_req for read ", name});
    check_value({name, " brk_idx"}, idx, brk_idx);
    check_value({name, " mem_wait"}, 1, mem_wait);
    repeat (6) begin // slow host
      @(negedge clk);
      check_value({name, " brk_req before ack"}, 1, brk_req);
      check_value({name, " mem_rvalid before ack"}, 0, mem_rvalid);
    end
    @(posedge clk);
    brk_ack <= 1'b1;
    cnt = 0;
    @(negedge clk);
    while (brk_req && cnt < 10) begin
      @(negedge clk);
      cnt++;
    end
    check_value({name, " brk_req after ack"}, 0, brk_req);
    repeat (4) begin
      @(negedge clk);
      check_value({name, " mem_wait while acked"}, 1, mem_wait);
      check_value({name, " mem_rvalid while acked"}, 0, mem_rvalid);
    end
    @(posedge clk);
    brk_ack <= 1'b0;
    @(posedge clk); // ack sampled low here
    wait_rvalid(name, exp, lat);
    check_value({name, " mem_wait at release"}, 0, mem_wait);
    @(posedge clk);
    mem_rd <= 1'b0;
    @(posedge clk);
  endtask

  initial begin : main
    addr_t addrs [N_RAND];
    byte_t datas [N_RAND];
    addr_t bp2_addr;
    addr_t bp5_addr;
    byte_t d2;
    byte_t d5;
    byte_t d_new;
    byte_t reply;
    int    rnd;
    rst       = 1'b1;
    mem_addr  = '0;
    mem_rd    = 1'b0;
    mem_wr    = 1'b0;
    mem_wdata = '0;
    brk_ack   = 1'b0;
    repeat (15) begin
      @(negedge clk);
      check_idle("in reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_idle("after reset");
    end

    query(OP_COOKIE, reply);
    check_value("get_cookie", EXP_COOKIE, reply);
    query(OP_VERSION, reply);
    check_value("get_version", EXP_VERSION, reply);
    @(negedge clk);
    check_value("miso between frames", 0, miso);

    // host writes then bus reads
    for (int i = 0; i < N_RAND; i++) begin
      rnd      = $random(seed);
      addrs[i] = {1'b1, i[2:0], rnd[11:0]}; // bits 14:12 keep the addresses apart
      datas[i] = rnd[19:12];
      poke(addrs[i], datas[i]);
    end
    for (int i = 0; i < N_RAND; i++) begin
      read_bus(addrs[i], datas[i], $sformatf("poke then bus read %0d", i));
    end
    for (int i = 0; i < N_LOW; i++) begin
      rnd = $random(seed);
      read_outside({1'b0, rnd[14:0]}, $sformatf("read below window %0d", i));
    end

    // bus writes then host reads
    for (int i = 0; i < N_RAND; i++) begin
      rnd      = $random(seed);
      addrs[i] = {1'b1, i[2:0], rnd[11:0]};
      datas[i] = rnd[19:12];
      write_bus(addrs[i], datas[i], $sformatf("bus write %0d", i));
    end
    for (int i = 0; i < N_RAND; i++) begin
      peek(addrs[i], reply);
      check_value($sformatf("bus write then peek %0d", i), datas[i], reply);
    end

    rnd      = $random(seed);
    bp2_addr = {4'b1010, rnd[11:0]};
    bp5_addr = {4'b1101, rnd[23:12]};
    d2       = rnd[31:24];
    rnd      = $random(seed);
    d5       = rnd[7:0];
    d_new    = rnd[15:8];
    poke(bp2_addr, d2);
    poke(bp5_addr, d5);
    set_breakpoint(3'd2, bp2_addr);
    set_breakpoint(3'd5, bp5_addr);
    one_byte_cmd(OP_ENABLE);
    read_halted(bp5_addr, 3'd5, d5, "halt at slot 5");
    set_breakpoint(3'd2, bp5_addr); // both slots now match
    read_halted(bp5_addr, 3'd2, d5, "shared address");

    one_byte_cmd(OP_DISABLE);
    read_bus(bp5_addr, d5, "breakpoints disabled");
    one_byte_cmd(OP_ENABLE);
    write_bus(bp5_addr, d_new, "write at breakpoint");
    clear_breakpoint(3'd2);
    read_halted(bp5_addr, 3'd5, d_new, "slot 2 cleared");
    clear_breakpoint(3'd5);
    read_bus(bp5_addr, d_new, "slot 5 cleared");

    $display("Test passed");
    $finish;
  end

endmodule

// ==== bench/spi_host.sv ====
module spi_host #(
  parameter int HALF = 8  // sck half period in clocks
) (
  input  logic clk,
  output logic sck,
  output logic mosi,
  output logic cs_n,
  input  logic miso
);

  initial begin
    sck  = 1'b0;
    mosi = 1'b0;
    cs_n = 1'b1;
  end

  // mode 0, mosi changes while sck is low and both sides sample on the rise
  task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      @(posedge clk);
      sck  <= 1'b0;
      mosi <= tx[i];
      repeat (HALF - 1) @(posedge clk);
      @(negedge clk);
      rx[i] = miso; // reply bit, stable since the last fall
      @(posedge clk);
      sck <= 1'b1;
      repeat (HALF - 1) @(posedge clk);
    end
  endtask

  // n bytes in one frame, returns what came back during the last one
  task automatic send_frame(input int n, input logic [7:0] b0, input logic [7:0] b1,
                            input logic [7:0] b2, input logic [7:0] b3,
                            output logic [7:0] last_rx);
    logic [7:0] tx [4];
    logic [7:0] rx;
    tx[0] = b0;
    tx[1] = b1;
    tx[2] = b2;
    tx[3] = b3;
    rx    = '0;
    @(posedge clk);
    cs_n <= 1'b0;
    repeat (HALF) @(posedge clk);
    for (int k = 0; k < n; k++) begin
      xfer_byte(tx[k], rx);
    end
    @(posedge clk);
    sck <= 1'b0;
    repeat (HALF) @(posedge clk);
    cs_n <= 1'b1;
    repeat (2 * HALF) @(posedge clk); // gap between frames
    last_rx = rx;
  endtask

endmodule

// ==== logic/trs_dbg_top.sv ====
module trs_dbg_top #(
  parameter int RAM_ADDR_W = trs_dbg_pkg::DEF_RAM_ADDR_W,
  parameter int NUM_BP     = trs_dbg_pkg::DEF_NUM_BP
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 sck,
  input  logic                 mosi,
  input  logic                 cs_n,
  output logic                 miso,
  input  trs_dbg_pkg::addr_t   mem_addr,
  input  logic                 mem_rd,
  input  logic                 mem_wr,
  input  trs_dbg_pkg::byte_t   mem_wdata,
  output trs_dbg_pkg::byte_t   mem_rdata,
  output logic                 mem_rvalid,
  output logic                 mem_wait,
  output logic                 brk_req,
  output trs_dbg_pkg::bp_idx_t brk_idx,
  input  logic                 brk_ack
);
  import trs_dbg_pkg::*;

  byte_t                 rx_byte;
  logic                  rx_valid;
  logic                  frame_start;
  byte_t                 tx_byte;
  logic                  tx_load;
  logic                  host_en;
  logic                  host_we;
  logic [RAM_ADDR_W-1:0] host_addr;
  byte_t                 host_wdata;
  byte_t                 host_rdata;
  logic                  bp_set;
  logic                  bp_clear;
  bp_idx_t               bp_sel;
  addr_t                 bp_addr;
  logic                  bp_enable;
  logic [NUM_BP-1:0]     hit;
  logic                  access_pulse;
  logic                  go;

  spi_target i_spi_target (
    .clk        (clk),
    .rst        (rst),
    .sck        (sck),
    .mosi       (mosi),
    .cs_n       (cs_n),
    .miso       (miso),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .frame_start(frame_start),
    .tx_byte    (tx_byte),
    .tx_load    (tx_load)
  );

  cmd_decoder #(
    .RAM_ADDR_W(RAM_ADDR_W)
  ) i_cmd_decoder (
    .clk        (clk),
    .rst        (rst),
    .rx_byte    (rx_byte),
    .rx_valid   (rx_valid),
    .frame_start(frame_start),
    .host_rdata (host_rdata),
    .tx_byte    (tx_byte),
    .tx_load    (tx_load),
    .host_en    (host_en),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .bp_set     (bp_set),
    .bp_clear   (bp_clear),
    .bp_sel     (bp_sel),
    .bp_addr    (bp_addr),
    .bp_enable  (bp_enable)
  );

  // one comparator per slot, all fed by the same write controls
  for (genvar g = 0; g < NUM_BP; g++) begin : g_slot
    bp_slot #(
      .SLOT(bp_idx_t'(g))
    ) i_bp_slot (
      .clk     (clk),
      .rst     (rst),
      .bp_set  (bp_set),
      .bp_clear(bp_clear),
      .bp_sel  (bp_sel),
      .bp_addr (bp_addr),
      .mem_addr(mem_addr),
      .hit     (hit[g])
    );
  end

  bp_halt_ctrl #(
    .NUM_BP(NUM_BP)
  ) i_bp_halt_ctrl (
    .clk         (clk),
    .rst         (rst),
    .hit         (hit),
    .bp_enable   (bp_enable),
    .mem_rd      (mem_rd),
    .mem_wr      (mem_wr),
    .mem_addr    (mem_addr),
    .brk_ack     (brk_ack),
    .access_pulse(access_pulse),
    .go          (go),
    .mem_wait    (mem_wait),
    .brk_req     (brk_req),
    .brk_idx     (brk_idx)
  );

  bus_ram #(
    .RAM_ADDR_W(RAM_ADDR_W)
  ) i_bus_ram (
    .clk         (clk),
    .access_pulse(access_pulse),
    .go          (go),
    .mem_addr    (mem_addr),
    .mem_rd      (mem_rd),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .mem_rvalid  (mem_rvalid),
    .host_en     (host_en),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_rdata  (host_rdata)
  );

endmodule

// ==== logic/bus_ram.sv ====
module bus_ram #(
  parameter int RAM_ADDR_W = trs_dbg_pkg::DEF_RAM_ADDR_W
) (
  input  logic                  clk,
  input  logic                  access_pulse,
  input  logic                  go,
  input  trs_dbg_pkg::addr_t    mem_addr,
  input  logic                  mem_rd,
  input  trs_dbg_pkg::byte_t    mem_wdata,
  output trs_dbg_pkg::byte_t    mem_rdata,
  output logic                  mem_rvalid,
  input  logic                  host_en,
  input  logic                  host_we,
  input  logic [RAM_ADDR_W-1:0] host_addr,
  input  trs_dbg_pkg::byte_t    host_wdata,
  output trs_dbg_pkg::byte_t    host_rdata
);
  import trs_dbg_pkg::*;

  byte_t mem [2**RAM_ADDR_W];

  // access captured at the strobe edge, kept while a halt is pending
  addr_t                 req_addr;
  logic                  req_rd;
  byte_t                 req_wdata;
  addr_t                 src_addr;
  logic                  src_rd;
  byte_t                 src_wdata;
  logic                  cmt_valid = 1'b0;
  logic                  cmt_rd;
  logic [RAM_ADDR_W-1:0] cmt_addr;
  byte_t                 cmt_wdata;
  byte_t                 rd_data;
  logic                  rd_done = 1'b0;
  logic                  rvalid_q = 1'b0;

  always_ff @(posedge clk) begin
    if (access_pulse) begin
      req_addr  <= mem_addr;
      req_rd    <= mem_rd;
      req_wdata <= mem_wdata;
    end
  end

  // a grant in the edge cycle bypasses the request register
  always_comb begin
    if (access_pulse) begin
      src_addr  = mem_addr;
      src_rd    = mem_rd;
      src_wdata = mem_wdata;
    end else begin
      src_addr  = req_addr;
      src_rd    = req_rd;
      src_wdata = req_wdata;
    end
  end

  always_ff @(posedge clk) begin
    cmt_valid <= go && src_addr[15]; // upper 32 KiB only
    if (go) begin
      cmt_rd    <= src_rd;
      cmt_addr  <= src_addr[RAM_ADDR_W-1:0];
      cmt_wdata <= src_wdata;
    end
  end

  // bus port
  always @(posedge clk) begin
    if (cmt_valid && !cmt_rd) begin
      mem[cmt_addr] <= cmt_wdata;
    end
    if (cmt_valid && cmt_rd) begin
      rd_data <= mem[cmt_addr];
    end
  end

  always_ff @(posedge clk) begin
    rd_done  <= cmt_valid && cmt_rd;
    rvalid_q <= rd_done;
    if (rd_done) begin
      mem_rdata <= rd_data;
    end
  end

  assign mem_rvalid = rvalid_q;

  // host port
  always @(posedge clk) begin
    if (host_en) begin
      if (host_we) begin
        mem[host_addr] <= host_wdata;
      end else begin
        host_rdata <= mem[host_addr];
      end
    end
  end

endmodule

// ==== logic/bp_halt_ctrl.sv ====
module bp_halt_ctrl #(
  parameter int NUM_BP = trs_dbg_pkg::DEF_NUM_BP
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_BP-1:0]    hit,
  input  logic                 bp_enable,
  input  logic                 mem_rd,
  input  logic                 mem_wr,
  input  trs_dbg_pkg::addr_t   mem_addr,
  input  logic                 brk_ack,
  output logic                 access_pulse,
  output logic                 go,
  output logic                 mem_wait,
  output logic                 brk_req,
  output trs_dbg_pkg::bp_idx_t brk_idx
);
  import trs_dbg_pkg::*;

  typedef enum logic [1:0] {ST_RUN, ST_WAIT_ACK, ST_WAIT_RELEASE} state_e;

  state_e     state;
  logic       rd_s;
  logic       wr_s;
  logic       stb_d;
  logic       strobe_edge;
  logic [1:0] ack_s;  // host ack is asynchronous
  logic       halt;
  bp_idx_t    first_hit;

  // lowest numbered slot wins
  always_comb begin
    first_hit = '0;
    for (int i = NUM_BP - 1; i >= 0; i--) begin
      if (hit[i]) begin
        first_hit = bp_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_s         <= 1'b0;
      wr_s         <= 1'b0;
      stb_d        <= 1'b0;
      access_pulse <= 1'b0;
      ack_s        <= '0;
    end else begin
      rd_s         <= mem_rd;
      wr_s         <= mem_wr;
      stb_d        <= rd_s | wr_s;
      access_pulse <= strobe_edge;
      ack_s        <= {ack_s[0], brk_ack};
    end
  end

  assign strobe_edge = (rd_s | wr_s) & ~stb_d;

  // only reads inside the ram window stop the bus
  assign halt = access_pulse && rd_s && mem_addr[15] && bp_enable && (|hit);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_RUN;
      brk_idx <= '0;
    end else begin
      case (state)
        ST_RUN: begin
          if (halt) begin
            state   <= ST_WAIT_ACK;
            brk_idx <= first_hit;
          end
        end
        ST_WAIT_ACK: begin
          if (ack_s[1]) begin
            state <= ST_WAIT_RELEASE;
          end
        end
        ST_WAIT_RELEASE: begin
          if (!ack_s[1]) begin
            state <= ST_RUN;
          end
        end
        default: state <= ST_RUN;
      endcase
    end
  end

  assign brk_req  = (state == ST_WAIT_ACK);
  assign mem_wait = (state != ST_RUN);
  assign go       = ((state == ST_RUN) && access_pulse && !halt) ||
                    ((state == ST_WAIT_RELEASE) && !ack_s[1]); // held read resumes

endmodule

// ==== logic/bp_slot.sv ====
module bp_slot #(
  parameter trs_dbg_pkg::bp_idx_t SLOT = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 bp_set,
  input  logic                 bp_clear,
  input  trs_dbg_pkg::bp_idx_t bp_sel,
  input  trs_dbg_pkg::addr_t   bp_addr,
  input  trs_dbg_pkg::addr_t   mem_addr,
  output logic                 hit
);
  import trs_dbg_pkg::*;

  addr_t bp_addr_q;
  logic  active;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
    end else if (bp_sel == SLOT) begin
      if (bp_set) begin
        active <= 1'b1;
      end else if (bp_clear) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bp_set && (bp_sel == SLOT)) begin
      bp_addr_q <= bp_addr;
    end
  end

  assign hit = active && (mem_addr == bp_addr_q); // full 16-bit compare

endmodule

// ==== logic/cmd_decoder.sv ====
module cmd_decoder #(
  parameter int RAM_ADDR_W = trs_dbg_pkg::DEF_RAM_ADDR_W
) (
  input  logic                  clk,
  input  logic                  rst,
  input  trs_dbg_pkg::byte_t    rx_byte,
  input  logic                  rx_valid,
  input  logic                  frame_start,
  input  trs_dbg_pkg::byte_t    host_rdata,
  output trs_dbg_pkg::byte_t    tx_byte,
  output logic                  tx_load,
  output logic                  host_en,
  output logic                  host_we,
  output logic [RAM_ADDR_W-1:0] host_addr,
  output trs_dbg_pkg::byte_t    host_wdata,
  output logic                  bp_set,
  output logic                  bp_clear,
  output trs_dbg_pkg::bp_idx_t  bp_sel,
  output trs_dbg_pkg::addr_t    bp_addr,
  output logic                  bp_enable
);
  import trs_dbg_pkg::*;

  typedef enum logic {ST_IDLE, ST_READ_PARAMS} state_e;

  state_e     state;
  cmd_e       cmd;
  byte_t      params [3];
  logic [1:0] n_params;  // parameter count of the incoming command byte
  logic [1:0] n_left;
  logic [1:0] p_idx;
  logic       fire;      // one-cycle action strobe
  logic       skip;      // next byte only clocks the reply out
  logic       peek_rdy;
  logic       has_reply;
  addr_t      ram_addr;

  always_comb begin
    case (cmd_e'(rx_byte))
      CMD_BRAM_POKE:        n_params = 2'd3;
      CMD_SET_BREAKPOINT:   n_params = 2'd3;
      CMD_BRAM_PEEK:        n_params = 2'd2;
      CMD_CLEAR_BREAKPOINT: n_params = 2'd1;
      default:              n_params = 2'd0;
    endcase
  end

  assign has_reply = (cmd == CMD_GET_COOKIE) || (cmd == CMD_GET_VERSION) ||
                     (cmd == CMD_BRAM_PEEK);

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      cmd    <= CMD_GET_COOKIE;
      n_left <= '0;
      p_idx  <= '0;
      fire   <= 1'b0;
      skip   <= 1'b0;
    end else begin
      fire <= 1'b0;
      if (frame_start) begin
        state <= ST_IDLE;
        skip  <= 1'b0;
      end else if (rx_valid) begin
        case (state)
          ST_IDLE: begin
            if (skip) begin
              skip <= 1'b0;
            end else begin
              cmd    <= cmd_e'(rx_byte);
              n_left <= n_params;
              p_idx  <= '0;
              if (n_params == 2'd0) begin
                fire <= 1'b1;
              end else begin
                state <= ST_READ_PARAMS;
              end
            end
          end
          ST_READ_PARAMS: begin
            p_idx  <= p_idx + 2'd1;
            n_left <= n_left - 2'd1;
            if (n_left == 2'd1) begin // last parameter
              fire  <= 1'b1;
              state <= ST_IDLE;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end else if (fire && has_reply) begin
        skip <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && (state == ST_READ_PARAMS)) begin
      params[p_idx] <= rx_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bp_enable <= 1'b0;
      peek_rdy  <= 1'b0;
    end else begin
      peek_rdy <= fire && (cmd == CMD_BRAM_PEEK); // ram data valid next cycle
      if (fire && (cmd == CMD_ENABLE_BREAKPOINTS)) begin
        bp_enable <= 1'b1;
      end else if (fire && (cmd == CMD_DISABLE_BREAKPOINTS)) begin
        bp_enable <= 1'b0;
      end
    end
  end

  // poke/peek params are addr lo, addr hi, data
  assign ram_addr   = {params[1], params[0]};
  assign host_addr  = ram_addr[RAM_ADDR_W-1:0];
  assign host_wdata = params[2];
  assign host_en    = fire && ((cmd == CMD_BRAM_POKE) || (cmd == CMD_BRAM_PEEK));
  assign host_we    = fire && (cmd == CMD_BRAM_POKE);

  // set params are slot, addr lo, addr hi
  assign bp_set   = fire && (cmd == CMD_SET_BREAKPOINT);
  assign bp_clear = fire && (cmd == CMD_CLEAR_BREAKPOINT);
  assign bp_sel   = params[0][2:0];
  assign bp_addr  = {params[2], params[1]};

  assign tx_load = peek_rdy || (fire && has_reply && (cmd != CMD_BRAM_PEEK));

  always_comb begin
    if (peek_rdy) begin
      tx_byte = host_rdata;
    end else if (cmd == CMD_GET_VERSION) begin
      tx_byte = {VERSION_MAJOR, VERSION_MINOR};
    end else begin
      tx_byte = COOKIE;
    end
  end

endmodule

// ==== logic/spi_target.sv ====
module spi_target (
  input  logic               clk,
  input  logic               rst,
  input  logic               sck,
  input  logic               mosi,
  input  logic               cs_n,
  output logic               miso,
  output trs_dbg_pkg::byte_t rx_byte,
  output logic               rx_valid,
  output logic               frame_start,
  input  trs_dbg_pkg::byte_t tx_byte,
  input  logic               tx_load
);
  import trs_dbg_pkg::*;

  logic [2:0] sck_q;  // two sync flops plus one for edge detection
  logic [2:0] cs_q;
  logic [1:0] mosi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bit_cnt;
  byte_t      rx_shift;
  byte_t      tx_shift;
  logic       miso_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_q <= '0;
      cs_q  <= '1; // deselected
    end else begin
      sck_q <= {sck_q[1:0], sck};
      cs_q  <= {cs_q[1:0], cs_n};
    end
  end

  always_ff @(posedge clk) begin
    mosi_q <= {mosi_q[0], mosi};
  end

  assign sck_rise    = (sck_q[2:1] == 2'b01);
  assign sck_fall    = (sck_q[2:1] == 2'b10);
  assign cs_active   = ~cs_q[1];
  assign frame_start = (cs_q[2:1] == 2'b10); // cs_n falling

  // receive side, mode 0 samples on rising sck
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7);
      if (!cs_active) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_q[1]}; // msb first
    end
  end

  assign rx_byte = rx_shift;

  // reply side, next bit goes out on falling sck
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_shift <= '0;
      miso_q   <= 1'b0;
    end else if (tx_load) begin
      tx_shift <= tx_byte;
    end else if (!cs_active) begin
      tx_shift <= '0;
      miso_q   <= 1'b0; // idle low between frames
    end else if (sck_fall) begin
      miso_q   <= tx_shift[7];
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign miso = miso_q;

endmodule

// ==== logic/trs_dbg_pkg.sv ====
package trs_dbg_pkg;

  // data byte on SPI or on the computer bus
  typedef logic [7:0] byte_t;

  // computer address space
  typedef logic [15:0] addr_t;

  // breakpoint slot number, at most 8 slots
  typedef logic [2:0] bp_idx_t;

  // host command codes, gaps are commands this core does not implement
  typedef enum logic [7:0] {
    CMD_GET_COOKIE          = 8'd0,
    CMD_BRAM_POKE           = 8'd1,
    CMD_BRAM_PEEK           = 8'd2,
    CMD_SET_BREAKPOINT      = 8'd6,
    CMD_CLEAR_BREAKPOINT    = 8'd7,
    CMD_ENABLE_BREAKPOINTS  = 8'd11,
    CMD_DISABLE_BREAKPOINTS = 8'd12,
    CMD_GET_VERSION         = 8'd15
  } cmd_e;

  // identity reply for get_cookie
  localparam byte_t COOKIE = 8'haf;

  // version reply byte is {major, minor}
  localparam logic [2:0] VERSION_MAJOR = 3'd0;
  localparam logic [4:0] VERSION_MINOR = 5'd3;

  // defaults for the top level parameters
  localparam int DEF_RAM_ADDR_W = 15; // 32 KiB window
  localparam int DEF_NUM_BP     = 8;  // 1 to 8

endpackage
